// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int xlen_c = 32;

    typedef logic [xlen_c-1:0] word_t;
    typedef logic [4:0]        reg_addr_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_none
    } alu_op_t;

    //////////////////////////////////////////////////
    // opcode fields
    //////////////////////////////////////////////////

    // every kept op except lu12i.w lives here
    localparam logic [5:0] opc_alu_31_26     = 6'h00;
    localparam logic [5:0] opc_lu12i_w_31_26 = 6'h05;

    // three-register group, selected by op_19_15
    localparam logic [3:0] opc_reg3_25_22  = 4'h0;
    localparam logic [1:0] opc_reg3_21_20  = 2'h1;
    localparam logic [4:0] opc_add_w_19_15 = 5'h00;
    localparam logic [4:0] opc_sub_w_19_15 = 5'h02;
    localparam logic [4:0] opc_slt_19_15   = 5'h04;
    localparam logic [4:0] opc_sltu_19_15  = 5'h05;
    localparam logic [4:0] opc_nor_19_15   = 5'h08;
    localparam logic [4:0] opc_and_19_15   = 5'h09;
    localparam logic [4:0] opc_or_19_15    = 5'h0a;
    localparam logic [4:0] opc_xor_19_15   = 5'h0b;
    localparam logic [4:0] opc_sll_w_19_15 = 5'h0e;
    localparam logic [4:0] opc_srl_w_19_15 = 5'h0f;
    localparam logic [4:0] opc_sra_w_19_15 = 5'h10;

    // shift by ui5
    localparam logic [3:0] opc_shift_25_22  = 4'h1;
    localparam logic [1:0] opc_shift_21_20  = 2'h0;
    localparam logic [4:0] opc_slli_w_19_15 = 5'h01;
    localparam logic [4:0] opc_srli_w_19_15 = 5'h09;
    localparam logic [4:0] opc_srai_w_19_15 = 5'h11;

    // 12-bit immediate group, op_25_22 alone decides
    localparam logic [3:0] opc_slti_25_22   = 4'h8;
    localparam logic [3:0] opc_sltui_25_22  = 4'h9;
    localparam logic [3:0] opc_addi_w_25_22 = 4'ha;
    localparam logic [3:0] opc_andi_25_22   = 4'hd;
    localparam logic [3:0] opc_ori_25_22    = 4'he;
    localparam logic [3:0] opc_xori_25_22   = 4'hf;

    // decode -> execute
    typedef struct packed {
        word_t     src1;
        word_t     src2;
        word_t     imm;
        alu_op_t   alu_op;
        logic      src2_is_imm;
        logic      gr_we;
        reg_addr_t dest;
    } exec_bundle_t;

    // execute -> result
    typedef struct packed {
        logic      gr_we;
        reg_addr_t dest;
        word_t     value;
    } result_bundle_t;

endpackage

`default_nettype wire

// ==== hdl/stage_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one pipeline link, valid/allow_in plus the forwarding view of the receiver
interface stage_if #(
    parameter type payload_t = logic
);
    logic               valid;
    payload_t           payload;
    logic               allow_in;

    // write still held by the receiving stage
    logic               fwd_valid;
    core_pkg::reg_addr_t fwd_dest;
    core_pkg::word_t    fwd_value;

    modport up (
        output valid, payload,
        input  allow_in, fwd_valid, fwd_dest, fwd_value
    );

    modport down (
        input  valid, payload,
        output allow_in, fwd_valid, fwd_dest, fwd_value
    );

    // read-only tap for stages further up
    modport fwd (
        input fwd_valid, fwd_dest, fwd_value
    );

endinterface

`default_nettype wire

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                 clk,
    input  wire                 reset,
    input  wire core_pkg::reg_addr_t raddr1,
    input  wire core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t     rdata1,
    output core_pkg::word_t     rdata2,
    input  wire                 we,
    input  wire core_pkg::reg_addr_t waddr,
    input  wire core_pkg::word_t wdata
);

    core_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 always reads zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : rf[raddr2];

endmodule

`default_nettype wire

// ==== hdl/inst_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
    input  wire                  clk,
    input  wire                  reset,
    input  wire core_pkg::word_t inst,
    input  wire                  inst_req,
    output logic                 inst_ack,
    output core_pkg::reg_addr_t  raddr1,
    output core_pkg::reg_addr_t  raddr2,
    input  wire core_pkg::word_t rdata1,
    input  wire core_pkg::word_t rdata2,
    stage_if.up                  link_exe,
    stage_if.fwd                 link_res
);

    logic                   dec_valid;
    core_pkg::word_t        inst_q;
    logic                   slot_free;
    logic                   capture;

    logic [5:0]             op_31_26;
    logic [3:0]             op_25_22;
    logic [1:0]             op_21_20;
    logic [4:0]             op_19_15;
    core_pkg::reg_addr_t    rd;
    core_pkg::reg_addr_t    rj;
    core_pkg::reg_addr_t    rk;
    logic [11:0]            i12;
    logic [19:0]            i20;

    logic                   is_alu_space;
    logic                   is_reg3;
    logic                   is_shift_imm;
    logic                   is_lu12i;
    logic                   need_si12;
    core_pkg::alu_op_t      alu_op;
    core_pkg::word_t        imm;
    core_pkg::word_t        rj_value;
    core_pkg::word_t        rk_value;
    core_pkg::exec_bundle_t dec_out;

    //////////////////////////////////////////////////
    // input handshake
    //////////////////////////////////////////////////

    // slot is free when empty or its word moves on this edge
    assign slot_free = !dec_valid || link_exe.allow_in;
    assign capture   = inst_req && !inst_ack && slot_free;

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_ack  <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            if (capture) begin
                inst_ack <= 1'b1;
            end else if (!inst_req) begin
                inst_ack <= 1'b0;
            end
            if (capture) begin
                dec_valid <= 1'b1;
            end else if (link_exe.allow_in) begin
                dec_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            inst_q <= inst;
        end
    end

    //////////////////////////////////////////////////
    // field decode
    //////////////////////////////////////////////////

    assign op_31_26 = inst_q[31:26];
    assign op_25_22 = inst_q[25:22];
    assign op_21_20 = inst_q[21:20];
    assign op_19_15 = inst_q[19:15];
    assign rd       = inst_q[4:0];
    assign rj       = inst_q[9:5];
    assign rk       = inst_q[14:10];
    assign i12      = inst_q[21:10];
    assign i20      = inst_q[24:5];

    assign is_alu_space = (op_31_26 == core_pkg::opc_alu_31_26);
    assign is_reg3      = is_alu_space && (op_25_22 == core_pkg::opc_reg3_25_22)
                          && (op_21_20 == core_pkg::opc_reg3_21_20);
    assign is_shift_imm = is_alu_space && (op_25_22 == core_pkg::opc_shift_25_22)
                          && (op_21_20 == core_pkg::opc_shift_21_20);
    // lu12i.w is a 7-bit opcode, bit 25 clear
    assign is_lu12i     = (op_31_26 == core_pkg::opc_lu12i_w_31_26) && !inst_q[25];

    always_comb begin
        alu_op = core_pkg::alu_none;
        if (is_reg3) begin
            case (op_19_15)
                core_pkg::opc_add_w_19_15: alu_op = core_pkg::alu_add;
                core_pkg::opc_sub_w_19_15: alu_op = core_pkg::alu_sub;
                core_pkg::opc_slt_19_15:   alu_op = core_pkg::alu_slt;
                core_pkg::opc_sltu_19_15:  alu_op = core_pkg::alu_sltu;
                core_pkg::opc_nor_19_15:   alu_op = core_pkg::alu_nor;
                core_pkg::opc_and_19_15:   alu_op = core_pkg::alu_and;
                core_pkg::opc_or_19_15:    alu_op = core_pkg::alu_or;
                core_pkg::opc_xor_19_15:   alu_op = core_pkg::alu_xor;
                core_pkg::opc_sll_w_19_15: alu_op = core_pkg::alu_sll;
                core_pkg::opc_srl_w_19_15: alu_op = core_pkg::alu_srl;
                core_pkg::opc_sra_w_19_15: alu_op = core_pkg::alu_sra;
                default:                   alu_op = core_pkg::alu_none;
            endcase
        end else if (is_shift_imm) begin
            case (op_19_15)
                core_pkg::opc_slli_w_19_15: alu_op = core_pkg::alu_sll;
                core_pkg::opc_srli_w_19_15: alu_op = core_pkg::alu_srl;
                core_pkg::opc_srai_w_19_15: alu_op = core_pkg::alu_sra;
                default:                    alu_op = core_pkg::alu_none;
            endcase
        end else if (is_alu_space) begin
            case (op_25_22)
                core_pkg::opc_addi_w_25_22: alu_op = core_pkg::alu_add;
                core_pkg::opc_slti_25_22:   alu_op = core_pkg::alu_slt;
                core_pkg::opc_sltui_25_22:  alu_op = core_pkg::alu_sltu;
                core_pkg::opc_andi_25_22:   alu_op = core_pkg::alu_and;
                core_pkg::opc_ori_25_22:    alu_op = core_pkg::alu_or;
                core_pkg::opc_xori_25_22:   alu_op = core_pkg::alu_xor;
                default:                    alu_op = core_pkg::alu_none;
            endcase
        end else if (is_lu12i) begin
            alu_op = core_pkg::alu_lui;
        end
    end

    //////////////////////////////////////////////////
    // immediate
    //////////////////////////////////////////////////

    // addi, slti and sltui sign-extend, logic ops zero-extend
    assign need_si12 = !is_reg3 && !is_shift_imm
                       && ((alu_op == core_pkg::alu_add)
                       || (alu_op == core_pkg::alu_slt)
                       || (alu_op == core_pkg::alu_sltu));

    assign imm = is_lu12i     ? {i20, 12'b0} :
                 is_shift_imm ? {27'b0, rk} :
                 need_si12    ? {{20{i12[11]}}, i12} :
                                {20'b0, i12};

    //////////////////////////////////////////////////
    // operands, execute beats result beats rf
    //////////////////////////////////////////////////

    assign raddr1 = rj;
    assign raddr2 = rk;

    assign rj_value = (link_exe.fwd_valid && link_exe.fwd_dest == rj) ? link_exe.fwd_value :
                      (link_res.fwd_valid && link_res.fwd_dest == rj) ? link_res.fwd_value :
                                                                        rdata1;
    assign rk_value = (link_exe.fwd_valid && link_exe.fwd_dest == rk) ? link_exe.fwd_value :
                      (link_res.fwd_valid && link_res.fwd_dest == rk) ? link_res.fwd_value :
                                                                        rdata2;

    always_comb begin
        dec_out.src1        = rj_value;
        dec_out.src2        = rk_value;
        dec_out.imm         = imm;
        dec_out.alu_op      = alu_op;
        dec_out.src2_is_imm = !is_reg3;
        // unknown encodings retire without a write
        dec_out.gr_we       = (alu_op != core_pkg::alu_none);
        dec_out.dest        = rd;
    end

    assign link_exe.valid   = dec_valid;
    assign link_exe.payload = dec_out;

endmodule

`default_nettype wire

// ==== hdl/alu_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_execute (
    input  wire    clk,
    input  wire    reset,
    stage_if.down  link_dec,
    stage_if.up    link_res
);

    logic                     exe_valid;
    core_pkg::exec_bundle_t   exe_q;
    core_pkg::word_t          opnd1;
    core_pkg::word_t          opnd2;
    core_pkg::word_t          alu_result;
    core_pkg::result_bundle_t res_out;

    assign link_dec.allow_in = !exe_valid || link_res.allow_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (link_dec.allow_in) begin
            exe_valid <= link_dec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (link_dec.valid && link_dec.allow_in) begin
            exe_q <= link_dec.payload;
        end
    end

    //////////////////////////////////////////////////
    // alu
    //////////////////////////////////////////////////

    assign opnd1 = exe_q.src1;
    assign opnd2 = exe_q.src2_is_imm ? exe_q.imm : exe_q.src2;

    always_comb begin
        case (exe_q.alu_op)
            core_pkg::alu_add:  alu_result = opnd1 + opnd2;
            core_pkg::alu_sub:  alu_result = opnd1 - opnd2;
            core_pkg::alu_slt:  alu_result = {31'b0, $signed(opnd1) < $signed(opnd2)};
            core_pkg::alu_sltu: alu_result = {31'b0, opnd1 < opnd2};
            core_pkg::alu_and:  alu_result = opnd1 & opnd2;
            core_pkg::alu_or:   alu_result = opnd1 | opnd2;
            core_pkg::alu_xor:  alu_result = opnd1 ^ opnd2;
            core_pkg::alu_nor:  alu_result = ~(opnd1 | opnd2);
            // shift amount is the low five bits
            core_pkg::alu_sll:  alu_result = opnd1 << opnd2[4:0];
            core_pkg::alu_srl:  alu_result = opnd1 >> opnd2[4:0];
            core_pkg::alu_sra:  alu_result = $signed(opnd1) >>> opnd2[4:0];
            core_pkg::alu_lui:  alu_result = exe_q.imm;
            default:            alu_result = '0;
        endcase
    end

    // decode sees this value in the same cycle
    assign link_dec.fwd_valid = exe_valid && exe_q.gr_we && (exe_q.dest != 5'd0);
    assign link_dec.fwd_dest  = exe_q.dest;
    assign link_dec.fwd_value = alu_result;

    always_comb begin
        res_out.gr_we = exe_q.gr_we;
        res_out.dest  = exe_q.dest;
        res_out.value = alu_result;
    end

    assign link_res.valid   = exe_valid;
    assign link_res.payload = res_out;

endmodule

`default_nettype wire

// ==== hdl/result_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_stage (
    input  wire                  clk,
    input  wire                  reset,
    stage_if.down                link_exe,
    output core_pkg::reg_addr_t  res_dest,
    output core_pkg::word_t      res_value,
    output logic                 res_req,
    input  wire                  res_ack,
    output logic                 we,
    output core_pkg::reg_addr_t  waddr,
    output core_pkg::word_t      wdata
);

    logic                     res_valid;
    core_pkg::result_bundle_t res_q;
    logic                     writes_reg;
    logic                     retire;

    // r0 targets and unknown ops count as no-write
    assign writes_reg = res_q.gr_we && (res_q.dest != 5'd0);
    assign retire     = res_req && res_ack;

    assign link_exe.allow_in = !res_valid || retire;

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (link_exe.allow_in) begin
            res_valid <= link_exe.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (link_exe.valid && link_exe.allow_in) begin
            res_q <= link_exe.payload;
        end
    end

    //////////////////////////////////////////////////
    // output handshake
    //////////////////////////////////////////////////

    // wait for ack low before offering the next result
    always_ff @(posedge clk) begin
        if (reset) begin
            res_req <= 1'b0;
        end else if (retire) begin
            res_req <= 1'b0;
        end else if (res_valid && !res_ack) begin
            res_req <= 1'b1;
        end
    end

    assign res_dest  = writes_reg ? res_q.dest : 5'd0;
    assign res_value = writes_reg ? res_q.value : '0;

    // write back on the ack edge
    assign we    = retire && writes_reg;
    assign waddr = res_q.dest;
    assign wdata = res_q.value;

    assign link_exe.fwd_valid = res_valid && writes_reg;
    assign link_exe.fwd_dest  = res_q.dest;
    assign link_exe.fwd_value = res_q.value;

endmodule

`default_nettype wire

// ==== hdl/alu_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_core_top (
    input  wire                  clk,
    input  wire                  reset,
    input  wire core_pkg::word_t inst,
    input  wire                  inst_req,
    output logic                 inst_ack,
    output core_pkg::reg_addr_t  res_dest,
    output core_pkg::word_t      res_value,
    output logic                 res_req,
    input  wire                  res_ack
);

    core_pkg::reg_addr_t raddr1;
    core_pkg::reg_addr_t raddr2;
    core_pkg::word_t     rdata1;
    core_pkg::word_t     rdata2;
    logic                rf_we;
    core_pkg::reg_addr_t rf_waddr;
    core_pkg::word_t     rf_wdata;

    stage_if #(.payload_t(core_pkg::exec_bundle_t))   dec_exe_link ();
    stage_if #(.payload_t(core_pkg::result_bundle_t)) exe_res_link ();

    inst_decode i_inst_decode (
        .clk      (clk),
        .reset    (reset),
        .inst     (inst),
        .inst_req (inst_req),
        .inst_ack (inst_ack),
        .raddr1   (raddr1),
        .raddr2   (raddr2),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .link_exe (dec_exe_link.up),
        .link_res (exe_res_link.fwd)
    );

    alu_execute i_alu_execute (
        .clk      (clk),
        .reset    (reset),
        .link_dec (dec_exe_link.down),
        .link_res (exe_res_link.up)
    );

    result_stage i_result_stage (
        .clk       (clk),
        .reset     (reset),
        .link_exe  (exe_res_link.down),
        .res_dest  (res_dest),
        .res_value (res_value),
        .res_req   (res_req),
        .res_ack   (res_ack),
        .we        (rf_we),
        .waddr     (rf_waddr),
        .wdata     (rf_wdata)
    );

    reg_file i_reg_file (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

endmodule

`default_nettype wire

// ==== sim/alu_core_model.svh ====
`ifndef ALU_CORE_MODEL_SVH
`define ALU_CORE_MODEL_SVH

//////////////////////////////////////////////////
// instruction kinds
//////////////////////////////////////////////////

localparam int k_add    = 0;
localparam int k_sub    = 1;
localparam int k_slt    = 2;
localparam int k_sltu   = 3;
localparam int k_and    = 4;
localparam int k_or     = 5;
localparam int k_xor    = 6;
localparam int k_nor    = 7;
localparam int k_sll    = 8;
localparam int k_srl    = 9;
localparam int k_sra    = 10;
localparam int k_addi   = 11;
localparam int k_slti   = 12;
localparam int k_sltui  = 13;
localparam int k_andi   = 14;
localparam int k_ori    = 15;
localparam int k_xori   = 16;
localparam int k_slli   = 17;
localparam int k_srli   = 18;
localparam int k_srai   = 19;
localparam int k_lu12i  = 20;
// everything from here on has no defined meaning
localparam int k_bad    = 21;
localparam int k_bad_rr = 22;

// LoongArch encodings, written as the upper opcode bits
function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [19:0] imm);
    logic [31:0] w;
    case (kind)
        k_add:    w = {17'h00020, rk, rj, rd};
        k_sub:    w = {17'h00022, rk, rj, rd};
        k_slt:    w = {17'h00024, rk, rj, rd};
        k_sltu:   w = {17'h00025, rk, rj, rd};
        k_nor:    w = {17'h00028, rk, rj, rd};
        k_and:    w = {17'h00029, rk, rj, rd};
        k_or:     w = {17'h0002a, rk, rj, rd};
        k_xor:    w = {17'h0002b, rk, rj, rd};
        k_sll:    w = {17'h0002e, rk, rj, rd};
        k_srl:    w = {17'h0002f, rk, rj, rd};
        k_sra:    w = {17'h00030, rk, rj, rd};
        k_slli:   w = {17'h00081, imm[4:0], rj, rd};
        k_srli:   w = {17'h00089, imm[4:0], rj, rd};
        k_srai:   w = {17'h00091, imm[4:0], rj, rd};
        k_slti:   w = {10'h008, imm[11:0], rj, rd};
        k_sltui:  w = {10'h009, imm[11:0], rj, rd};
        k_addi:   w = {10'h00a, imm[11:0], rj, rd};
        k_andi:   w = {10'h00d, imm[11:0], rj, rd};
        k_ori:    w = {10'h00e, imm[11:0], rj, rd};
        k_xori:   w = {10'h00f, imm[11:0], rj, rd};
        k_lu12i:  w = {7'h0a, imm, rd};
        // unused slot in the three-register group
        k_bad_rr: w = {17'h0003f, rk, rj, rd};
        default:  w = {6'h3f, imm, rj, 1'b1};
    endcase
    return w;
endfunction

// value written by one instruction, a and b are the rj and rk contents
function automatic logic [31:0] alu_model(input int kind, input logic [31:0] a,
                                          input logic [31:0] b, input logic [19:0] imm);
    logic [31:0] si12;
    logic [31:0] ui12;
    logic [31:0] r;
    si12 = {{20{imm[11]}}, imm[11:0]};
    ui12 = {20'h0, imm[11:0]};
    case (kind)
        k_add:   r = a + b;
        k_sub:   r = a - b;
        k_slt:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        k_sltu:  r = (a < b) ? 32'd1 : 32'd0;
        k_and:   r = a & b;
        k_or:    r = a | b;
        k_xor:   r = a ^ b;
        k_nor:   r = ~(a | b);
        k_sll:   r = a << b[4:0];
        k_srl:   r = a >> b[4:0];
        k_sra:   r = $signed(a) >>> b[4:0];
        k_addi:  r = a + si12;
        k_slti:  r = ($signed(a) < $signed(si12)) ? 32'd1 : 32'd0;
        // compare against the sign-extended value, but unsigned
        k_sltui: r = (a < si12) ? 32'd1 : 32'd0;
        k_andi:  r = a & ui12;
        k_ori:   r = a | ui12;
        k_xori:  r = a ^ ui12;
        k_slli:  r = a << imm[4:0];
        k_srli:  r = a >> imm[4:0];
        k_srai:  r = $signed(a) >>> imm[4:0];
        k_lu12i: r = {imm, 12'h000};
        default: r = 32'h0;
    endcase
    return r;
endfunction

`endif

// ==== sim/alu_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_core_tb;

    localparam int clk_period_c   = 40;
    localparam int reset_cycles_c = 8;

    localparam int n_cold_c    = 4;
    localparam int n_seed_c    = 62;
    localparam int n_rr_c      = 60;
    localparam int n_imm_dir_c = 15;
    localparam int n_imm_c     = 40;
    localparam int n_chain_c   = 32;
    localparam int n_zero_c    = 12;
    localparam int n_total_c   = n_cold_c + n_seed_c + n_rr_c + n_imm_dir_c + n_imm_c
                                 + n_chain_c + n_zero_c;

    logic        clk;
    logic        reset;
    logic [31:0] inst;
    logic        inst_req;
    wire         inst_ack;
    wire  [4:0]  res_dest;
    wire  [31:0] res_value;
    wire         res_req;
    logic        res_ack;

    // reference register state in program order
    logic [31:0] regs [32];
    logic [36:0] expect_q [$];

    logic [31:0] stim_state = 32'd83090;
    logic [31:0] ack_state  = 32'd83090;

    int mismatch_count = 0;
    int protocol_count = 0;
    int count_errors   = 0;
    int tx_count       = 0;
    int rx_count       = 0;

    logic req_at_edge = 1'b0;
    logic ack_prev    = 1'b0;

    `include "alu_core_model.svh"

    alu_core_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .inst_req  (inst_req),
        .inst_ack  (inst_ack),
        .res_dest  (res_dest),
        .res_value (res_value),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period_c / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////
    // random numbers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // low LCG bits are weak, so only upper halves are used
    function automatic logic [31:0] next_stim_word();
        logic [31:0] hi;
        stim_state = lcg_step(stim_state);
        hi = stim_state;
        stim_state = lcg_step(stim_state);
        return {hi[31:16], stim_state[31:16]};
    endfunction

    function automatic int ack_delay();
        ack_state = lcg_step(ack_state);
        return ack_state[31:16] % 21;
    endfunction

    task automatic report_counts();
        $display("errors: mismatch=%0d protocol=%0d count=%0d, results %0d of %0d",
                 mismatch_count, protocol_count, count_errors, rx_count, tx_count);
    endtask

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    task automatic drive_handshake(input logic [31:0] word);
        int gap;
        gap = next_stim_word() % 4;
        repeat (gap) @(negedge clk);
        inst     = word;
        inst_req = 1'b1;
        @(negedge clk);
        while (!inst_ack) @(negedge clk);
        inst_req = 1'b0;
        // the captured word must not follow the bus any more
        inst     = next_stim_word();
        @(negedge clk);
        while (inst_ack) @(negedge clk);
    endtask

    task automatic issue(input int kind, input logic [4:0] rd, input logic [4:0] rj,
                         input logic [4:0] rk, input logic [19:0] imm);
        logic [31:0] value;
        logic [4:0]  dest;
        value = alu_model(kind, regs[rj], regs[rk], imm);
        if (kind < k_bad && rd != 5'd0) begin
            dest     = rd;
            regs[rd] = value;
        end else begin
            dest  = 5'd0;
            value = 32'h0;
        end
        expect_q.push_back({dest, value});
        tx_count++;
        drive_handshake(encode(kind, rd, rj, rk, imm));
    endtask

    // inst_ack may only move in step with inst_req
    always @(posedge clk) begin
        req_at_edge <= inst_req;
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (inst_ack && !ack_prev && !req_at_edge) begin
                protocol_count++;
                $display("inst_ack rose while inst_req was low");
            end
            if (!inst_ack && ack_prev && req_at_edge) begin
                protocol_count++;
                $display("inst_ack fell while inst_req was still high");
            end
        end
        ack_prev = inst_ack;
    end

    //////////////////////////////////////////////////
    // output side and scoreboard
    //////////////////////////////////////////////////

    initial begin : response_check
        logic [36:0] expected;
        logic [4:0]  seen_dest;
        logic [31:0] seen_value;
        int          delay;
        res_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (res_req && !res_ack) begin
                seen_dest  = res_dest;
                seen_value = res_value;
                rx_count++;
                if (expect_q.size() == 0) begin
                    count_errors++;
                    $display("extra result for dest %0d with no instruction outstanding",
                             res_dest);
                end else begin
                    expected = expect_q.pop_front();
                    if (res_dest !== expected[36:32]) begin
                        mismatch_count++;
                        $display("MISMATCH res_dest: expected %h got %h",
                                 expected[36:32], res_dest);
                    end
                    if (res_value !== expected[31:0]) begin
                        mismatch_count++;
                        $display("MISMATCH res_value: expected %h got %h",
                                 expected[31:0], res_value);
                    end
                end
                delay = ack_delay();
                repeat (delay) @(negedge clk);
                if (!res_req || res_dest !== seen_dest || res_value !== seen_value) begin
                    protocol_count++;
                    $display("result changed or was withdrawn before res_ack");
                end
                res_ack = 1'b1;
                @(negedge clk);
                while (res_req) @(negedge clk);
                res_ack = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] w;
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [4:0]  prev;
        int          i;
        reset    = 1'b1;
        inst     = 32'h0;
        inst_req = 1'b0;
        for (i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        repeat (reset_cycles_c) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (inst_ack !== 1'b0 || res_req !== 1'b0) begin
            protocol_count++;
            $display("inst_ack or res_req not low after reset");
        end

        // nothing written yet, every read sees 0
        issue(k_add, 5, 6, 7, 0);
        issue(k_or, 8, 31, 1, 0);
        issue(k_addi, 9, 20, 0, 20'h007ff);
        issue(k_sltu, 10, 3, 4, 0);

        // seed every register
        for (i = 1; i < 32; i++) begin
            w = next_stim_word();
            issue(k_lu12i, i, 0, 0, w[31:12]);
            issue(k_ori, i, i, 0, {8'h0, w[11:0]});
        end

        for (i = 0; i < n_rr_c; i++) begin
            w = next_stim_word();
            issue(w[31:24] % 11, w[4:0], w[12:8], w[20:16], 0);
        end

        // extension corners
        issue(k_addi, 1, 2, 0, 20'h00fff);
        issue(k_addi, 3, 4, 0, 20'h00800);
        issue(k_slti, 5, 6, 0, 20'h00800);
        issue(k_sltui, 7, 8, 0, 20'h00fff);
        issue(k_andi, 9, 10, 0, 20'h00f0f);
        issue(k_ori, 11, 12, 0, 20'h00800);
        issue(k_xori, 13, 14, 0, 20'h00fff);
        issue(k_slli, 15, 16, 0, 20'h00000);
        issue(k_slli, 17, 18, 0, 20'h0001f);
        issue(k_srli, 19, 20, 0, 20'h0001f);
        issue(k_lu12i, 22, 0, 0, 20'h80000);
        issue(k_srai, 21, 22, 0, 20'h0001f);
        issue(k_srai, 23, 24, 0, 20'h00000);
        issue(k_lu12i, 25, 0, 0, 20'h80000);
        issue(k_lu12i, 26, 0, 0, 20'hfffff);

        for (i = 0; i < n_imm_c; i++) begin
            w   = next_stim_word();
            imm = next_stim_word();
            issue(k_addi + w[31:24] % 10, w[4:0], w[12:8], 0, imm);
        end

        // each one reads the destination of the one before
        prev = 5'd7;
        for (i = 0; i < n_chain_c; i++) begin
            w   = next_stim_word();
            imm = next_stim_word();
            rd  = (w[4:0] == 5'd0) ? 5'd1 : w[4:0];
            issue(w[31:24] % 21, rd, prev, w[8] ? prev : w[20:16], imm);
            prev = rd;
        end

        // r0 targets and undefined encodings
        for (i = 0; i < n_zero_c / 4; i++) begin
            w  = next_stim_word();
            rd = (w[4:0] == 5'd0) ? 5'd2 : w[4:0];
            issue(k_addi, 0, w[12:8], 0, w[31:12]);
            issue(k_bad, rd, w[12:8], 0, w[31:12]);
            issue(k_bad_rr, rd, w[12:8], w[20:16], 0);
            issue(k_add, w[20:16], 0, rd, 0);
        end

        while (rx_count < tx_count) @(negedge clk);
        repeat (60) @(negedge clk);
        if (rx_count != tx_count || expect_q.size() != 0) begin
            count_errors++;
            $display("got %0d results for %0d instructions", rx_count, tx_count);
        end
        report_counts();
        if (mismatch_count + protocol_count + count_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // worst case is a full ack delay plus both handshakes per instruction
    initial begin
        #((reset_cycles_c + n_total_c * 30) * clk_period_c);
        $display("timeout: only %0d of %0d results arrived", rx_count, n_total_c);
        report_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+sim
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/reg_file.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/result_stage.sv
hdl/alu_core_top.sv
sim/alu_core_tb.sv
